//--- common/mipsPkg.sv
`default_nettype none

package mipsPkg;

    // opcode field values
    localparam logic [5:0] opSpecial = 6'h00; // register-register group
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opLw      = 6'h23;
    localparam logic [5:0] opSw      = 6'h2b;
    localparam logic [5:0] opBeq     = 6'h04;

    // function field values of the special opcode
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr  = 3'd3,
        aluSlt = 3'd4  // signed compare
    } aluOp_t;

    // operand source in execute
    typedef enum logic [1:0] {
        fwdReg = 2'd0, // value read in decode
        fwdMem = 2'd1, // memory stage result
        fwdWb  = 2'd2  // writeback result
    } fwdSel_t;

    typedef struct packed {
        logic   regWrite;
        logic   memToReg;
        logic   memWrite;
        logic   aluSrcImm;
        logic   regDstRt;  // write rt instead of rd
        logic   branch;
        aluOp_t aluOp;
    } decodeCtrl_t;

    typedef struct packed {
        decodeCtrl_t ctrl;
        logic [31:0] pcPlus4;
        logic [31:0] readA;
        logic [31:0] readB;
        logic [31:0] imm;      // sign extended
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  writeReg; // already picked from rd or rt
    } stageDE_t;

    typedef struct packed {
        logic        regWrite;
        logic        memToReg;
        logic        memWrite;
        logic [31:0] aluOut;
        logic [31:0] storeData;
        logic [4:0]  writeReg;
    } stageEM_t;

    typedef struct packed {
        logic        regWrite;
        logic [31:0] result;
        logic [4:0]  writeReg;
    } stageMW_t;

endpackage

`default_nettype wire

//--- hw/datapath/pipeReg.sv
`timescale 1ns/10ps
`default_nettype none

// one stage register with the payload chosen per instance
module pipeReg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     reset,
    input  logic     stall,
    input  logic     flush,
    input  payload_t din,
    output payload_t dout
);

    always_ff @(posedge clk) begin
        if (reset || flush) begin
            dout <= '0;      // all-zero payload is a bubble
        end else if (!stall) begin
            dout <= din;
        end
    end

endmodule

`default_nettype wire

//--- hw/datapath/regFile.sv
`timescale 1ns/10ps
`default_nettype none

module regFile (
    input  logic        clk,
    input  logic [4:0]  readAddrA,
    input  logic [4:0]  readAddrB,
    output logic [31:0] readA,
    output logic [31:0] readB,
    input  logic        writeEn,
    input  logic [4:0]  writeAddr,
    input  logic [31:0] writeData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (writeEn && writeAddr != 5'd0) begin
            regs[writeAddr] <= writeData;
        end
    end

    // write-through lets decode see a value retiring this cycle
    function automatic logic [31:0] readPort(input logic [4:0] addr);
        if (addr == 5'd0) begin
            return 32'd0;
        end else if (writeEn && writeAddr == addr) begin
            return writeData;
        end
        return regs[addr];
    endfunction

    assign readA = readPort(readAddrA);
    assign readB = readPort(readAddrB);

endmodule

`default_nettype wire

//--- hw/datapath/alu.sv
`timescale 1ns/10ps
`default_nettype none

module alu import mipsPkg::*; (
    input  logic [31:0] a,
    input  logic [31:0] b,
    input  aluOp_t      op,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            aluAdd:  result = a + b;
            aluSub:  result = a - b;            // also used by beq
            aluAnd:  result = a & b;
            aluOr:   result = a | b;
            aluSlt:  result = {31'd0, $signed(a) < $signed(b)};
            default: result = 32'd0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

`default_nettype wire

//--- hw/datapath/datapath.sv
`timescale 1ns/10ps
`default_nettype none

module datapath import mipsPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] aluoutM,
    output logic [31:0] writedataM,
    output logic        memWrite,
    input  logic [31:0] readData,
    output logic [31:0] instrD,
    input  decodeCtrl_t ctrlD,
    output logic [4:0]  rsD,
    output logic [4:0]  rtD,
    output logic [4:0]  rsE,
    output logic [4:0]  rtE,
    output logic [4:0]  writeRegE,
    output logic [4:0]  writeRegM,
    output logic [4:0]  writeRegW,
    output logic        memToRegE,
    output logic        regWriteM,
    output logic        regWriteW,
    output logic        branchTaken,
    input  logic        stallF,
    input  logic        stallD,
    input  logic        flushD,
    input  logic        flushE,
    input  fwdSel_t     fwdA,
    input  fwdSel_t     fwdB
);

    logic [31:0] pcPlus4F, pcNext, branchTarget;
    logic [31:0] pcPlus4D, immD, readAD, readBD;
    logic [4:0]  rdD;
    logic [31:0] srcA, srcB, fwdValB, aluResult, resultM;
    logic        zeroE;
    stageDE_t    deIn, deOut;
    stageEM_t    emIn, emOut;
    stageMW_t    mwIn, mwOut;

    // fetch
    assign pcPlus4F = pc + 32'd4;
    assign pcNext   = branchTaken ? branchTarget : pcPlus4F;

    always_ff @(posedge clk) begin
        if (reset) begin
            pc <= resetPc;
        end else if (branchTaken || !stallF) begin
            pc <= pcNext;  // taken beq wins over a hold
        end
    end

    always_ff @(posedge clk) begin
        if (reset || flushD) begin
            instrD   <= 32'd0;     // zero word decodes as nop
            pcPlus4D <= 32'd0;
        end else if (!stallD) begin
            instrD   <= instr;
            pcPlus4D <= pcPlus4F;
        end
    end

    // decode
    assign rsD  = instrD[25:21];
    assign rtD  = instrD[20:16];
    assign rdD  = instrD[15:11];
    assign immD = {{16{instrD[15]}}, instrD[15:0]};

    regFile i_regFile (
        .clk       (clk),
        .readAddrA (rsD),
        .readAddrB (rtD),
        .readA     (readAD),
        .readB     (readBD),
        .writeEn   (mwOut.regWrite),
        .writeAddr (mwOut.writeReg),
        .writeData (mwOut.result)
    );

    always_comb begin
        deIn.ctrl     = ctrlD;
        deIn.pcPlus4  = pcPlus4D;
        deIn.readA    = readAD;
        deIn.readB    = readBD;
        deIn.imm      = immD;
        deIn.rs       = rsD;
        deIn.rt       = rtD;
        deIn.writeReg = ctrlD.regDstRt ? rtD : rdD;
    end

    pipeReg #(.payload_t(stageDE_t)) i_regDE (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(flushE), .din(deIn), .dout(deOut)
    );

    // execute
    assign rsE       = deOut.rs;
    assign rtE       = deOut.rt;
    assign writeRegE = deOut.writeReg;
    assign memToRegE = deOut.ctrl.memToReg;

    function automatic logic [31:0] fwdMux(input fwdSel_t sel, input logic [31:0] regVal);
        case (sel)
            fwdMem:  return resultM;
            fwdWb:   return mwOut.result;
            default: return regVal;
        endcase
    endfunction

    assign srcA    = fwdMux(fwdA, deOut.readA);
    assign fwdValB = fwdMux(fwdB, deOut.readB);
    assign srcB    = deOut.ctrl.aluSrcImm ? deOut.imm : fwdValB;

    alu i_alu (
        .a      (srcA),
        .b      (srcB),
        .op     (deOut.ctrl.aluOp),
        .result (aluResult),
        .zero   (zeroE)
    );

    assign branchTaken  = deOut.ctrl.branch & zeroE;  // beq subtracts rs - rt
    assign branchTarget = deOut.pcPlus4 + {deOut.imm[29:0], 2'b00};

    always_comb begin
        emIn.regWrite  = deOut.ctrl.regWrite;
        emIn.memToReg  = deOut.ctrl.memToReg;
        emIn.memWrite  = deOut.ctrl.memWrite;
        emIn.aluOut    = aluResult;
        emIn.storeData = fwdValB;        // forwarded rt rather than the immediate
        emIn.writeReg  = deOut.writeReg;
    end

    pipeReg #(.payload_t(stageEM_t)) i_regEM (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .din(emIn), .dout(emOut)
    );

    // memory
    assign aluoutM    = emOut.aluOut;
    assign writedataM = emOut.storeData;
    assign memWrite   = emOut.memWrite;
    assign regWriteM  = emOut.regWrite;
    assign writeRegM  = emOut.writeReg;
    assign resultM    = emOut.memToReg ? readData : emOut.aluOut;

    always_comb begin
        mwIn.regWrite = emOut.regWrite;
        mwIn.result   = resultM;
        mwIn.writeReg = emOut.writeReg;
    end

    pipeReg #(.payload_t(stageMW_t)) i_regMW (
        .clk(clk), .reset(reset), .stall(1'b0), .flush(1'b0), .din(mwIn), .dout(mwOut)
    );

    // writeback
    assign regWriteW = mwOut.regWrite;
    assign writeRegW = mwOut.writeReg;

endmodule

`default_nettype wire

//--- hw/controlDecoder.sv
`timescale 1ns/10ps
`default_nettype none

module controlDecoder import mipsPkg::*; (
    input  logic [31:0] instrD,
    output decodeCtrl_t ctrlD
);

    logic [5:0] opcode;
    logic [5:0] funct;

    assign opcode = instrD[31:26];
    assign funct  = instrD[5:0];

    always_comb begin
        ctrlD = '0;                      // unknown encodings stay a nop
        case (opcode)
            opSpecial: begin
                ctrlD.regWrite = 1'b1;
                case (funct)
                    fnAddu:  ctrlD.aluOp = aluAdd;
                    fnSubu:  ctrlD.aluOp = aluSub;
                    fnAnd:   ctrlD.aluOp = aluAnd;
                    fnOr:    ctrlD.aluOp = aluOr;
                    fnSlt:   ctrlD.aluOp = aluSlt;
                    default: ctrlD = '0; // includes the all-zero word
                endcase
            end
            opAddiu: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.regDstRt  = 1'b1;
                ctrlD.aluOp     = aluAdd;
            end
            opLw: begin
                ctrlD.regWrite  = 1'b1;
                ctrlD.memToReg  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.regDstRt  = 1'b1;
                ctrlD.aluOp     = aluAdd;  // base plus offset
            end
            opSw: begin
                ctrlD.memWrite  = 1'b1;
                ctrlD.aluSrcImm = 1'b1;
                ctrlD.aluOp     = aluAdd;
            end
            opBeq: begin
                ctrlD.branch = 1'b1;
                ctrlD.aluOp  = aluSub;     // zero flag means equal
            end
            default: ctrlD = '0;
        endcase
    end

endmodule

`default_nettype wire

//--- hw/hazardUnit.sv
`timescale 1ns/10ps
`default_nettype none

module hazardUnit import mipsPkg::*; (
    input  logic [4:0] rsD,
    input  logic [4:0] rtD,
    input  logic [4:0] rsE,
    input  logic [4:0] rtE,
    input  logic [4:0] writeRegE,
    input  logic [4:0] writeRegM,
    input  logic [4:0] writeRegW,
    input  logic       memToRegE,
    input  logic       regWriteM,
    input  logic       regWriteW,
    input  logic       branchTaken,
    output logic       stallF,
    output logic       stallD,
    output logic       flushD,
    output logic       flushE,
    output fwdSel_t    fwdA,
    output fwdSel_t    fwdB
);

    logic loadUse;

    // younger producer first
    function automatic fwdSel_t pickSource(input logic [4:0] srcReg);
        if (regWriteM && writeRegM != 5'd0 && writeRegM == srcReg) begin
            return fwdMem;
        end else if (regWriteW && writeRegW != 5'd0 && writeRegW == srcReg) begin
            return fwdWb;
        end
        return fwdReg;
    endfunction

    assign fwdA = pickSource(rsE);
    assign fwdB = pickSource(rtE);

    // load in execute feeding the instruction in decode
    assign loadUse = memToRegE && (writeRegE == rsD || writeRegE == rtD);

    assign stallF = loadUse;
    assign stallD = loadUse;
    assign flushD = branchTaken;
    assign flushE = loadUse | branchTaken;  // bubble or squashed slot

endmodule

`default_nettype wire

//--- hw/cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module cpuTop import mipsPkg::*; #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        reset,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    output logic [31:0] aluoutM,
    output logic [31:0] writedataM,
    output logic        memWrite,
    input  logic [31:0] readData
);

    logic [31:0] instrD;
    decodeCtrl_t ctrlD;
    logic [4:0]  rsD, rtD, rsE, rtE;
    logic [4:0]  writeRegE, writeRegM, writeRegW;
    logic        memToRegE, regWriteM, regWriteW, branchTaken;
    logic        stallF, stallD, flushD, flushE;
    fwdSel_t     fwdA, fwdB;

    datapath #(.resetPc(resetPc)) i_datapath (
        .clk(clk), .reset(reset), .pc(pc), .instr(instr),
        .aluoutM(aluoutM), .writedataM(writedataM), .memWrite(memWrite), .readData(readData),
        .instrD(instrD), .ctrlD(ctrlD),
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .memToRegE(memToRegE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .branchTaken(branchTaken),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
        .fwdA(fwdA), .fwdB(fwdB)
    );

    controlDecoder i_controlDecoder (
        .instrD (instrD),
        .ctrlD  (ctrlD)
    );

    hazardUnit i_hazardUnit (
        .rsD(rsD), .rtD(rtD), .rsE(rsE), .rtE(rtE),
        .writeRegE(writeRegE), .writeRegM(writeRegM), .writeRegW(writeRegW),
        .memToRegE(memToRegE), .regWriteM(regWriteM), .regWriteW(regWriteW),
        .branchTaken(branchTaken),
        .stallF(stallF), .stallD(stallD), .flushD(flushD), .flushE(flushE),
        .fwdA(fwdA), .fwdB(fwdB)
    );

endmodule

`default_nettype wire

//--- verification/cpuTop_props.sv
`timescale 1ns/10ps
`default_nettype none

// bound into datapath to watch its strobes and hazard controls
module cpuTop_props (
    input logic        clk,
    input logic        reset,
    input logic [31:0] pc,
    input logic        memWrite,
    input logic        flushD,
    input logic        stallD
);

    // a reset edge clears the memory-stage payload
    memWriteInReset: assert property (
        @(posedge clk) $past(reset) |-> !memWrite
    ) else $error("memWrite high after a cycle in reset");

    // sequential fetch and branch targets are word multiples
    pcAligned: assert property (
        @(posedge clk) disable iff (reset) pc[1:0] == 2'b00
    ) else $error("pc 32'h%08h is not word aligned", pc);

    // load-use stall and taken branch need different instructions in execute
    flushStallExclusive: assert property (
        @(posedge clk) !(flushD && stallD)
    ) else $error("flushD and stallD are high in the same cycle");

endmodule

`default_nettype wire

//--- verification/tb_cpuTop.sv
`timescale 1ns/10ps
`default_nettype none

module tb_cpuTop;

    localparam int clkHalf      = 50;
    localparam int resetCycles  = 8;
    localparam int storeTimeout = 40;  // cycles allowed between two stores
    localparam int drainCycles  = 20;
    localparam int numStores    = 12;

    // MIPS encoding fields
    localparam logic [5:0] opRtype = 6'h00;
    localparam logic [5:0] opAddiu = 6'h09;
    localparam logic [5:0] opLw    = 6'h23;
    localparam logic [5:0] opSw    = 6'h2b;
    localparam logic [5:0] opBeq   = 6'h04;
    localparam logic [5:0] fnAddu  = 6'h21;
    localparam logic [5:0] fnSubu  = 6'h23;
    localparam logic [5:0] fnAnd   = 6'h24;
    localparam logic [5:0] fnOr    = 6'h25;
    localparam logic [5:0] fnSlt   = 6'h2a;

    typedef struct packed {
        logic [31:0] addr;
        logic [31:0] data;
    } storeEntry_t;

    logic        clk;
    logic        reset;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [31:0] aluoutM;
    logic [31:0] writedataM;
    logic        memWrite;
    logic [31:0] readData;

    logic [31:0] progMem [64];
    logic [31:0] dataMem [64];
    storeEntry_t expStores [numStores];
    int          progLen;

    cpuTop #(.resetPc(32'h0000_0000)) i_dut (
        .clk        (clk),
        .reset      (reset),
        .pc         (pc),
        .instr      (instr),
        .aluoutM    (aluoutM),
        .writedataM (writedataM),
        .memWrite   (memWrite),
        .readData   (readData)
    );

    bind datapath cpuTop_props i_props (
        .clk(clk), .reset(reset), .pc(pc), .memWrite(memWrite),
        .flushD(flushD), .stallD(stallD)
    );

    // unused words stay zero and decode as nop
    assign instr    = (pc[31:8] == 24'd0) ? progMem[pc[7:2]] : 32'd0;
    assign readData = dataMem[aluoutM[7:2]];

    always @(posedge clk) begin
        if (memWrite) begin
            dataMem[aluoutM[7:2]] <= writedataM;
        end
    end

    initial begin
        clk = 1'b0;
        forever begin
            #clkHalf clk = ~clk;
        end
    end

    function automatic logic [31:0] encodeR(input logic [5:0] funct, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [4:0] rd);
        return {opRtype, rs, rt, rd, 5'd0, funct};
    endfunction

    function automatic logic [31:0] encodeI(input logic [5:0] op, input logic [4:0] rs,
                                            input logic [4:0] rt, input logic [15:0] imm);
        return {op, rs, rt, imm};
    endfunction

    task automatic addInstr(input logic [31:0] word);
        progMem[progLen[5:0]] = word;
        progLen++;
    endtask

    task automatic loadProgram();
        for (int i = 0; i < 64; i++) begin
            progMem[i[5:0]] = 32'd0;
        end
        progLen = 0;
        addInstr(encodeI(opAddiu, 5'd0, 5'd1, 16'h005a));  // $1 = 0x5a
        addInstr(encodeI(opAddiu, 5'd1, 5'd2, 16'h0033));  // $2 = 0x8d
        addInstr(encodeI(opSw, 5'd0, 5'd2, 16'd0));
        addInstr(encodeR(fnAddu, 5'd1, 5'd2, 5'd3));        // $3 = 0xe7
        addInstr(encodeI(opSw, 5'd0, 5'd3, 16'd4));
        addInstr(encodeR(fnSubu, 5'd3, 5'd1, 5'd4));        // $4 = 0x8d
        addInstr(encodeI(opSw, 5'd0, 5'd4, 16'd8));
        addInstr(encodeR(fnAnd, 5'd4, 5'd3, 5'd5));         // $5 = 0x85
        addInstr(encodeI(opSw, 5'd0, 5'd5, 16'd12));
        addInstr(encodeR(fnOr, 5'd5, 5'd1, 5'd6));          // $6 = 0xdf
        addInstr(encodeI(opSw, 5'd0, 5'd6, 16'd16));
        addInstr(encodeI(opAddiu, 5'd0, 5'd7, 16'h0123));  // load-use sequence
        addInstr(encodeI(opSw, 5'd0, 5'd7, 16'd20));
        addInstr(encodeI(opLw, 5'd0, 5'd8, 16'd20));
        addInstr(encodeR(fnAddu, 5'd8, 5'd6, 5'd9));        // $9 = 0x202
        addInstr(encodeI(opSw, 5'd0, 5'd9, 16'd24));
        addInstr(encodeI(opAddiu, 5'd0, 5'd10, 16'h0bad)); // marker value
        addInstr(encodeI(opBeq, 5'd8, 5'd7, 16'd2));        // taken
        addInstr(encodeI(opSw, 5'd0, 5'd10, 16'd28));
        addInstr(encodeI(opSw, 5'd0, 5'd10, 16'd32));
        addInstr(encodeI(opBeq, 5'd1, 5'd2, 16'd1));        // not taken
        addInstr(encodeI(opSw, 5'd0, 5'd9, 16'd28));
        addInstr(encodeI(opAddiu, 5'd0, 5'd11, 16'hfffa)); // $11 = -6
        addInstr(encodeI(opAddiu, 5'd0, 5'd12, 16'd9));
        addInstr(encodeR(fnSlt, 5'd11, 5'd12, 5'd13));
        addInstr(encodeI(opSw, 5'd0, 5'd13, 16'd36));
        addInstr(encodeR(fnSlt, 5'd12, 5'd11, 5'd14));
        addInstr(encodeI(opSw, 5'd0, 5'd14, 16'd40));
        addInstr(encodeR(fnSubu, 5'd12, 5'd6, 5'd15));      // 9 - 0xdf wraps
        addInstr(encodeI(opSw, 5'd0, 5'd15, 16'd44));
        addInstr(encodeI(opAddiu, 5'd0, 5'd0, 16'h0055));  // write to $0 is dropped
        addInstr(encodeI(opSw, 5'd0, 5'd0, 16'd48));
    endtask

    task automatic loadExpected();
        expStores[0]  = '{addr: 32'd0,  data: 32'h0000_008d};  // 0x5a + 0x33
        expStores[1]  = '{addr: 32'd4,  data: 32'h0000_00e7};  // 0x5a + 0x8d
        expStores[2]  = '{addr: 32'd8,  data: 32'h0000_008d};  // 0xe7 - 0x5a
        expStores[3]  = '{addr: 32'd12, data: 32'h0000_0085};  // 0x8d & 0xe7
        expStores[4]  = '{addr: 32'd16, data: 32'h0000_00df};  // 0x85 | 0x5a
        expStores[5]  = '{addr: 32'd20, data: 32'h0000_0123};
        expStores[6]  = '{addr: 32'd24, data: 32'h0000_0202};  // 0x123 + 0xdf
        expStores[7]  = '{addr: 32'd28, data: 32'h0000_0202};
        expStores[8]  = '{addr: 32'd36, data: 32'h0000_0001};  // -6 < 9
        expStores[9]  = '{addr: 32'd40, data: 32'h0000_0000};
        expStores[10] = '{addr: 32'd44, data: 32'hffff_ff2a};  // 9 - 223
        expStores[11] = '{addr: 32'd48, data: 32'h0000_0000};
    endtask

    task automatic fillDataMem();
        for (int i = 0; i < 64; i++) begin
            dataMem[i[5:0]] <= 32'hc0de_0000 + 32'(i) * 32'd4;  // byte address pattern
        end
    endtask

    task automatic stopWithError(input string reason);
        $display("%s", reason);
        $display("Done: errors found");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected) begin
            stopWithError($sformatf("Error at time %0d ns: %s is 32'h%08h, expected 32'h%08h",
                                    $time, name, actual, expected));
        end
    endtask

    task automatic waitForStore(input int index);
        int cycles;
        cycles = 0;
        @(negedge clk);
        while (!memWrite && cycles < storeTimeout) begin
            cycles++;
            @(negedge clk);
        end
        if (!memWrite) begin
            stopWithError($sformatf("Timeout: store %0d did not appear within %0d cycles",
                                    index, storeTimeout));
        end
    endtask

    task automatic checkNoMoreStores();
        repeat (drainCycles) begin
            @(negedge clk);
            if (memWrite) begin
                stopWithError($sformatf("Unexpected extra store to address 32'h%08h", aluoutM));
            end
        end
    endtask

    initial begin
        reset = 1'b1;
        loadProgram();
        loadExpected();
        fillDataMem();
        repeat (resetCycles - 1) @(posedge clk);
        @(negedge clk);
        checkValue("pc", pc, 32'h0000_0000);
        checkValue("memWrite", {31'd0, memWrite}, 32'd0);
        @(posedge clk);
        #1 reset = 1'b0;
        for (int i = 0; i < numStores; i++) begin
            waitForStore(i);
            checkValue("aluoutM", aluoutM, expStores[i].addr);
            checkValue("writedataM", writedataM, expStores[i].data);
        end
        checkNoMoreStores();
        $display("Done: no errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- sim.f
common/mipsPkg.sv
hw/datapath/pipeReg.sv
hw/datapath/regFile.sv
hw/datapath/alu.sv
hw/datapath/datapath.sv
hw/controlDecoder.sv
hw/hazardUnit.sv
hw/cpuTop.sv
verification/cpuTop_props.sv
verification/tb_cpuTop.sv

//--- run.sh
#!/bin/sh
# Build and run the cpuTop testbench with Verilator.
# Exit status is 0 only for a clean run.

cd "$(dirname "$0")" || exit 1

LOG=sim.log
FAIL_TEXT="Done: errors found"

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module tb_cpuTop -f sim.f --Mdir obj_dir -o tb_cpuTop
if [ $? -ne 0 ]; then
    echo "run.sh: Verilator build failed"
    exit 1
fi

./obj_dir/tb_cpuTop > "$LOG" 2>&1
runStatus=$?
cat "$LOG"

if grep -q "$FAIL_TEXT" "$LOG"; then
    echo "run.sh: testbench reported errors, see $LOG"
    exit 1
fi

if [ $runStatus -ne 0 ]; then
    echo "run.sh: simulation exited with status $runStatus"
    exit 1
fi

echo "run.sh: simulation passed"
exit 0
